//--- include/pm_defs.svh
/*
	opcodes, field widths, state codes and step timing
	for the P-M control unit
*/
`ifndef PM_DEFS_SVH
`define PM_DEFS_SVH

// opcodes
`define PM_OP_HLT	6'd1
`define PM_OP_SHIFT	6'd2
`define PM_OP_LRG	6'd3

// instruction field widths
`define PM_OP_W		6
`define PM_REG_W	3
`define PM_T_W		6
`define PM_LG_W		2
`define PM_STATE_W	3

// main loop state codes
`define PM_ST_P0	3'd0
`define PM_ST_P1	3'd1
`define PM_ST_P2	3'd2
`define PM_ST_P3	3'd3
`define PM_ST_P4	3'd4
`define PM_ST_P5	3'd5

// step timing
`define PM_STEP_LEN	3
`define PM_PH_W		2
`define PM_LG_LAST	2'd3

`endif

//--- src/pm_pkg.sv
/*
	types shared by the P-M unit: main loop state,
	two-format instruction word, microoperation bundle
*/
`include "pm_defs.svh"

package pm_pkg;

	// main loop states P0..P5
	typedef enum logic [`PM_STATE_W-1:0] {
		st_p0 = `PM_ST_P0,	// idle
		st_p1 = `PM_ST_P1,	// instruction fetch
		st_p2 = `PM_ST_P2,	// argument fetch
		st_p3 = `PM_ST_P3,	// B-modification
		st_p4 = `PM_ST_P4,	// execute
		st_p5 = `PM_ST_P5	// interrupt accept
	} pm_state_t;

	// normal format with three register fields
	typedef struct packed {
		logic [`PM_OP_W-1:0] op;
		logic d;
		logic [`PM_REG_W-1:0] a;
		logic [`PM_REG_W-1:0] b;
		logic [`PM_REG_W-1:0] c;
	} pm_instr_norm_t;

	// short format, b and c fields merged into t
	typedef struct packed {
		logic [`PM_OP_W-1:0] op;
		logic d;
		logic [`PM_REG_W-1:0] a;
		logic [`PM_T_W-1:0] t;
	} pm_instr_short_t;

	typedef union packed {
		pm_instr_norm_t n;
		pm_instr_short_t s;
	} pm_instr_u;

	// register selector, W bus strobes and memory request
	typedef struct packed {
		logic [`PM_REG_W-1:0] reg_sel;
		logic w_r;
		logic w_ic;
		logic w_ir;
		logic w_ar;
		logic w_ac;
		logic shift_step;
		logic int_ack;
		logic mem_req;
	} pm_microops_t;

endpackage

//--- src/pm_timing.sv
/*
	step timer: strob1, strob2 and end-of-step pulse,
	held before strob2 while a memory access is pending
*/
`include "pm_defs.svh"

module pm_timing (
	input __clk,
	input rst,
	input pm_pkg::pm_state_t state,
	input mem_wait,
	input mem_done,
	output logic strob1,
	output logic strob2,
	output logic step_end
);

	import pm_pkg::*;

	localparam logic [`PM_PH_W-1:0] PH_S1 = `PM_PH_W'd0;
	localparam logic [`PM_PH_W-1:0] PH_S2 = `PM_PH_W'd1;
	localparam logic [`PM_PH_W-1:0] PH_END = `PM_PH_W'(`PM_STEP_LEN - 1);

	logic [`PM_PH_W-1:0] ph;
	logic hold;

	// stay in front of strob2 while memory is busy
	assign hold = mem_wait & ~mem_done;

	always_ff @(posedge __clk) begin
		if (rst) begin
			ph <= PH_S1;
		end else if (state == st_p0) begin
			// next step starts with strob1
			ph <= PH_S1;
		end else begin
			case (ph)
				PH_S1: ph <= PH_S2;
				PH_S2: begin
					if (!hold)
						ph <= PH_END;
				end
				default: ph <= PH_S1;
			endcase
		end
	end

	assign strob1 = (state != st_p0) && (ph == PH_S1);
	assign strob2 = (ph == PH_S2) && !hold;
	assign step_end = (ph == PH_END);

	a_strobes_apart: assert property (@(posedge __clk) disable iff (rst)
		!(strob1 && strob2));

endmodule

//--- src/pm_sequencer.sv
/*
	main loop sequencer: START/WAIT flip-flops, state register,
	instruction register, memory wait and next-state choice
*/
`include "pm_defs.svh"

module pm_sequencer (
	input __clk,
	input rst,
	input start_req,
	input stop_req,
	input irq,
	input irq_mask,
	input mem_done,
	input pm_pkg::pm_instr_u instr,
	input strob2,
	input step_end,
	input lk_zero,
	input lg_last,
	output pm_pkg::pm_state_t state,
	output pm_pkg::pm_instr_u ir,
	output logic mem_wait,
	output logic run,
	output logic wait_flag
);

	import pm_pkg::*;

	logic start_q;
	logic wait_q;
	logic is_short;
	logic is_lrg;
	logic p4_again;
	logic int_go;
	logic state_upd;
	pm_state_t state_nx;
	pm_state_t state_leave;

	assign run = start_q & ~wait_q;
	assign wait_flag = wait_q;

	assign is_short = (ir.s.op == `PM_OP_SHIFT);
	assign is_lrg = (ir.n.op == `PM_OP_LRG);

	// START, cleared by stop at any time
	always_ff @(posedge __clk) begin
		if (rst)
			start_q <= 1'b0;
		else if (stop_req)
			start_q <= 1'b0;
		else if (start_req && state == st_p0)
			start_q <= 1'b1;
	end

	// WAIT, set by HLT in execute
	always_ff @(posedge __clk) begin
		if (rst)
			wait_q <= 1'b0;
		else if (start_req && state == st_p0)
			wait_q <= 1'b0;
		else if (state == st_p4 && strob2 && ir.n.op == `PM_OP_HLT)
			wait_q <= 1'b1;
	end

	// decides loop exit and dispatch
	assign p4_again = is_short ? !lk_zero : (is_lrg && !lg_last);
	assign int_go = irq && !irq_mask && state != st_p5;

	always_comb begin
		if (int_go)
			state_leave = st_p5;
		else if (wait_q || !start_q)
			state_leave = st_p0;
		else
			state_leave = st_p1;
	end

	always_comb begin
		state_nx = state;
		case (state)
			st_p0: begin
				if (run)
					state_nx = st_p1;
			end
			st_p1: begin
				if (ir.n.c == '0 && !is_short)
					state_nx = st_p2;
				else if (ir.n.b != '0)
					state_nx = st_p3;
				else
					state_nx = st_p4;
			end
			st_p2: state_nx = (ir.n.b != '0) ? st_p3 : st_p4;
			st_p3: state_nx = st_p4;
			st_p4: state_nx = p4_again ? st_p4 : state_leave;
			st_p5: state_nx = state_leave;
			default: state_nx = st_p0;
		endcase
	end

	// P0 has no step timing, leaves as soon as run is up
	assign state_upd = step_end || (state == st_p0);

	always_ff @(posedge __clk) begin
		if (rst) begin
			state <= st_p0;
			mem_wait <= 1'b0;
		end else begin
			if (state_upd)
				state <= state_nx;
			if (state_upd && (state_nx == st_p1 || state_nx == st_p2))
				mem_wait <= 1'b1;
			else if (mem_done)
				mem_wait <= 1'b0;
		end
	end

	always_ff @(posedge __clk) begin
		if (rst)
			ir <= '0;
		else if (state == st_p1 && mem_done)
			ir <= instr;
	end

	a_p0_hold: assert property (@(posedge __clk) disable iff (rst)
		(state == st_p0 && !run) |=> state == st_p0);

endmodule

//--- src/pm_counters.sv
/*
	group counter (LG) and step counter (LK)
	for multi-register transfers and shifts
*/
`include "pm_defs.svh"

module pm_counters (
	input __clk,
	input rst,
	input pm_pkg::pm_state_t state,
	input pm_pkg::pm_instr_u ir,
	input strob1,
	input step_end,
	output logic [`PM_LG_W-1:0] lg,
	output logic lg_last,
	output logic lk_zero
);

	import pm_pkg::*;

	logic [`PM_T_W-1:0] lk;
	logic is_shift;
	logic is_lrg;

	assign is_shift = (ir.s.op == `PM_OP_SHIFT);
	assign is_lrg = (ir.n.op == `PM_OP_LRG);

	// step counter, preset from t until execute begins
	always_ff @(posedge __clk) begin
		if (rst)
			lk <= '0;
		else if (state != st_p4)
			lk <= ir.s.t;
		else if (is_shift && strob1 && !lk_zero)
			lk <= lk - 1'b1;
	end

	assign lk_zero = (lk == '0);

	// group counter, one register per execute step
	always_ff @(posedge __clk) begin
		if (rst)
			lg <= '0;
		else if (state != st_p4)
			lg <= '0;
		else if (is_lrg && step_end)
			lg <= lg + 1'b1;
	end

	assign lg_last = (lg == `PM_LG_LAST);

	// once empty in execute, LK stays empty
	a_lk_floor: assert property (@(posedge __clk) disable iff (rst)
		(state == st_p4 && lk_zero) |=> (state != st_p4 || lk_zero));

endmodule

//--- src/pm_microops.sv
/*
	microoperation decoder: register selector, W bus strobes,
	interrupt acknowledge and memory request per state and strobe
*/
`include "pm_defs.svh"

module pm_microops (
	input pm_pkg::pm_state_t state,
	input pm_pkg::pm_instr_u ir,
	input strob1,
	input strob2,
	input [`PM_LG_W-1:0] lg,
	input mem_wait,
	input mem_done,
	output pm_pkg::pm_microops_t uops
);

	import pm_pkg::*;

	logic is_shift;
	logic is_lrg;
	logic mem_state;

	assign is_shift = (ir.s.op == `PM_OP_SHIFT);
	assign is_lrg = (ir.n.op == `PM_OP_LRG);
	assign mem_state = (state == st_p1) || (state == st_p2);

	always_comb begin
		uops = '0;
		uops.reg_sel = ir.n.a;

		// request drops with the done pulse
		uops.mem_req = mem_state && mem_wait && !mem_done;

		case (state)
			st_p1: begin
				uops.w_ir = strob2;
				uops.w_ic = strob2;
			end
			st_p2: begin
				uops.w_ic = strob2;
				uops.w_ac = strob2;
			end
			st_p3: begin
				// B-modification reads register b
				uops.reg_sel = ir.n.b;
				uops.w_ac = strob2;
			end
			st_p4: begin
				if (is_lrg) begin
					uops.reg_sel = ir.n.a + {1'b0, lg};
					uops.w_r = strob2;
				end
				// t of zero gives a single step with no shift
				if (is_shift)
					uops.shift_step = strob1 && (ir.s.t != '0);
			end
			st_p5: begin
				uops.int_ack = strob2;
				uops.w_ar = strob2;
			end
		endcase
	end

endmodule

//--- src/pm_top.sv
/*
	P-M control unit top level
*/
module pm_top (
	input __clk,
	input rst,
	input start_req,
	input stop_req,
	input irq,
	input irq_mask,
	input mem_done,
	input pm_pkg::pm_instr_u instr,
	output pm_pkg::pm_state_t state,
	output logic run,
	output logic wait_flag,
	output pm_pkg::pm_microops_t uops
);

	import pm_pkg::*;

	pm_instr_u ir;
	logic mem_wait;
	logic strob1;
	logic strob2;
	logic step_end;
	logic [1:0] lg;
	logic lg_last;
	logic lk_zero;

	pm_timing i_timing (
		.__clk(__clk),
		.rst(rst),
		.state(state),
		.mem_wait(mem_wait),
		.mem_done(mem_done),
		.strob1(strob1),
		.strob2(strob2),
		.step_end(step_end)
	);

	pm_sequencer i_sequencer (
		.__clk(__clk),
		.rst(rst),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.irq_mask(irq_mask),
		.mem_done(mem_done),
		.instr(instr),
		.strob2(strob2),
		.step_end(step_end),
		.lk_zero(lk_zero),
		.lg_last(lg_last),
		.state(state),
		.ir(ir),
		.mem_wait(mem_wait),
		.run(run),
		.wait_flag(wait_flag)
	);

	pm_counters i_counters (
		.__clk(__clk),
		.rst(rst),
		.state(state),
		.ir(ir),
		.strob1(strob1),
		.step_end(step_end),
		.lg(lg),
		.lg_last(lg_last),
		.lk_zero(lk_zero)
	);

	pm_microops i_microops (
		.state(state),
		.ir(ir),
		.strob1(strob1),
		.strob2(strob2),
		.lg(lg),
		.mem_wait(mem_wait),
		.mem_done(mem_done),
		.uops(uops)
	);

endmodule

//--- sim/tb_pm.sv
/*
	testbench for the P-M control unit: clock, reset, memory model
	with random delays, reference state tracking and assertions
*/
`include "pm_defs.svh"

module tb_pm;

	timeunit 1ns;
	timeprecision 100ps;

	import pm_pkg::*;

	localparam int PROG_LEN = 8;
	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic rst;
	logic start_req;
	logic stop_req;
	logic irq;
	logic irq_mask;
	logic mem_done;
	pm_instr_u instr;
	pm_state_t state;
	logic run;
	logic wait_flag;
	pm_microops_t uops;

	// reference model of the main loop
	pm_instr_u prog [PROG_LEN];
	pm_instr_u cur;
	pm_state_t cnt_state;
	pm_state_t exp_nx_q;
	logic exp_start;
	logic exp_wait;
	logic seen_start;
	int n_wir;
	int n_shift;
	int n_wr;
	int n_ack;
	int n_wic;
	int n_wac;
	int n_war;
	int exp_shifts;
	int exp_wr;
	int exp_wic;
	int exp_wac;
	int exp_war;
	logic [2:0] exp_reg;
	logic [31:0] lcg_state;
	int pc;

	pm_top i_dut (
		.__clk(clk),
		.rst(rst),
		.start_req(start_req),
		.stop_req(stop_req),
		.irq(irq),
		.irq_mask(irq_mask),
		.mem_done(mem_done),
		.instr(instr),
		.state(state),
		.run(run),
		.wait_flag(wait_flag),
		.uops(uops)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run();
		$display("Test failures found");
		$fatal(1, "stopping at first error");
	endtask

	task automatic mismatch(string test, int expected, int actual);
		$display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
		fail_run();
	endtask

	task automatic timed_out(string what);
		$display("timeout while waiting for %s", what);
		fail_run();
	endtask

	function automatic pm_instr_u encode(logic [5:0] op, logic [2:0] a, logic [2:0] b,
			logic [2:0] c);
		pm_instr_u w;
		w.n.op = op;
		w.n.d = 1'b0;
		w.n.a = a;
		w.n.b = b;
		w.n.c = c;
		return w;
	endfunction

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// dispatch rules of the main loop
	function automatic pm_state_t next_state(pm_state_t s, pm_instr_u w, logic irq_v,
			logic mask_v, logic halted, logic started);
		pm_state_t nx;
		case (s)
			st_p0: nx = (started && !halted) ? st_p1 : st_p0;
			st_p1: begin
				if (w.n.c == 3'd0 && w.s.op != `PM_OP_SHIFT)
					nx = st_p2;
				else if (w.n.b != 3'd0)
					nx = st_p3;
				else
					nx = st_p4;
			end
			st_p2: nx = (w.n.b != 3'd0) ? st_p3 : st_p4;
			st_p3: nx = st_p4;
			default: begin
				if (irq_v && !mask_v && s != st_p5)
					nx = st_p5;
				else if (halted || !started)
					nx = st_p0;
				else
					nx = st_p1;
			end
		endcase
		return nx;
	endfunction

	task automatic wait_for_state(pm_state_t s, string what);
		int n;
		n = 0;
		@(posedge clk);
		while (state != s) begin
			n++;
			if (n > WAIT_LIMIT)
				timed_out(what);
			@(posedge clk);
		end
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#2 start_req = 1'b1;
		@(posedge clk);
		#2 start_req = 1'b0;
	endtask

	task automatic pulse_stop();
		@(posedge clk);
		#2 stop_req = 1'b1;
		@(posedge clk);
		#2 stop_req = 0;
	endtask

	// pulse counts per state visit, flags, expected next state
	always @(posedge clk) begin
		if (rst) begin
			cnt_state <= st_p0;
			exp_nx_q <= st_p0;
			cur <= '0;
			exp_start <= 1'b0;
			exp_wait <= 1'b0;
			seen_start <= 1'b0;
			n_wir <= 0;
			n_shift <= 0;
			n_wr <= 0;
			n_ack <= 0;
			n_wic <= 0;
			n_wac <= 0;
			n_war <= 0;
		end else begin
			if (state != cnt_state) begin
				cnt_state <= state;
				n_wir <= int'(uops.w_ir);
				n_shift <= int'(uops.shift_step);
				n_wr <= int'(uops.w_r);
				n_ack <= int'(uops.int_ack);
				n_wic <= int'(uops.w_ic);
				n_wac <= int'(uops.w_ac);
				n_war <= int'(uops.w_ar);
				if (cnt_state == st_p4 && cur.n.op == `PM_OP_HLT)
					exp_wait <= 1'b1;
			end else begin
				n_wir <= n_wir + int'(uops.w_ir);
				n_shift <= n_shift + int'(uops.shift_step);
				n_wr <= n_wr + int'(uops.w_r);
				n_ack <= n_ack + int'(uops.int_ack);
				n_wic <= n_wic + int'(uops.w_ic);
				n_wac <= n_wac + int'(uops.w_ac);
				n_war <= n_war + int'(uops.w_ar);
			end
			if (mem_done && state == st_p1)
				cur <= instr;
			if (start_req)
				seen_start <= 1'b1;
			if (stop_req)
				exp_start <= 1'b0;
			else if (start_req && state == st_p0)
				exp_start <= 1'b1;
			if (start_req && state == st_p0)
				exp_wait <= 1'b0;
			exp_nx_q <= next_state(state, cur, irq, irq_mask,
				exp_wait || (state == st_p4 && cur.n.op == `PM_OP_HLT), exp_start);
		end
	end

	always_comb begin
		exp_shifts = (cur.s.op == `PM_OP_SHIFT) ? int'(cur.s.t) : 0;
		exp_wr = (cur.n.op == `PM_OP_LRG) ? int'(`PM_LG_LAST) + 1 : 0;
		exp_reg = cur.n.a + ((state == cnt_state) ? n_wr[2:0] : 3'd0);
		// one W bus strobe per step in the states that use it
		exp_wic = (cnt_state == st_p1 || cnt_state == st_p2) ? 1 : 0;
		exp_wac = (cnt_state == st_p2 || cnt_state == st_p3) ? 1 : 0;
		exp_war = (cnt_state == st_p5) ? 1 : 0;
	end

	a_reset_idle: assert property (@(posedge clk) disable iff (rst)
		!seen_start |-> {state, run, wait_flag, uops} == '0)
		else mismatch("reset idle", 0, int'($sampled({state, run, wait_flag, uops})));

	a_mem_req_held: assert property (@(posedge clk) disable iff (rst)
		$fell(uops.mem_req) |-> mem_done)
		else mismatch("mem_req until mem_done", 1, int'($sampled(mem_done)));

	a_next_state: assert property (@(posedge clk) disable iff (rst)
		state != cnt_state |-> state == exp_nx_q)
		else mismatch("next state", int'($sampled(exp_nx_q)), int'($sampled(state)));

	a_one_wir: assert property (@(posedge clk) disable iff (rst)
		(state != cnt_state && cnt_state == st_p1) |-> n_wir == 1)
		else mismatch("w_ir per fetch", 1, $sampled(n_wir));

	a_wic_count: assert property (@(posedge clk) disable iff (rst)
		state != cnt_state |-> n_wic == exp_wic)
		else mismatch("w_ic per state", $sampled(exp_wic), $sampled(n_wic));

	a_wac_count: assert property (@(posedge clk) disable iff (rst)
		state != cnt_state |-> n_wac == exp_wac)
		else mismatch("w_ac per state", $sampled(exp_wac), $sampled(n_wac));

	a_war_count: assert property (@(posedge clk) disable iff (rst)
		state != cnt_state |-> n_war == exp_war)
		else mismatch("w_ar per state", $sampled(exp_war), $sampled(n_war));

	a_bmod_sel: assert property (@(posedge clk) disable iff (rst)
		state == st_p3 |-> uops.reg_sel == cur.n.b)
		else mismatch("reg_sel in P3", int'($sampled(cur.n.b)), int'($sampled(uops.reg_sel)));

	a_plain_sel: assert property (@(posedge clk) disable iff (rst)
		(state != st_p3 && !(state == st_p4 && cur.n.op == `PM_OP_LRG)) |->
			uops.reg_sel == cur.n.a)
		else mismatch("reg_sel from a", int'($sampled(cur.n.a)), int'($sampled(uops.reg_sel)));

	a_shift_count: assert property (@(posedge clk) disable iff (rst)
		(state != cnt_state && cnt_state == st_p4) |-> n_shift == exp_shifts)
		else mismatch("shift steps", $sampled(exp_shifts), $sampled(n_shift));

	a_lrg_count: assert property (@(posedge clk) disable iff (rst)
		(state != cnt_state && cnt_state == st_p4) |-> n_wr == exp_wr)
		else mismatch("register group writes", $sampled(exp_wr), $sampled(n_wr));

	a_lrg_sel: assert property (@(posedge clk) disable iff (rst)
		(state == st_p4 && uops.w_r) |-> uops.reg_sel == exp_reg)
		else mismatch("reg_sel in LRG", int'($sampled(exp_reg)), int'($sampled(uops.reg_sel)));

	a_int_ack: assert property (@(posedge clk) disable iff (rst)
		(state != cnt_state && cnt_state == st_p5) |-> n_ack == 1)
		else mismatch("int_ack per accept", 1, $sampled(n_ack));

	a_idle_flags: assert property (@(posedge clk) disable iff (rst)
		(state == st_p0 && cnt_state == st_p0) |->
			{run, wait_flag} == {exp_start && !exp_wait, exp_wait})
		else mismatch("run and wait in P0",
			int'({$sampled(exp_start) && !$sampled(exp_wait), $sampled(exp_wait)}),
			int'($sampled({run, wait_flag})));

	// memory answers each request after 1 to 6 clocks
	initial begin : memory_model
		int delay;
		int idle;
		mem_done = 1'b0;
		instr = '0;
		pc = 0;
		lcg_state = 32'hc429;
		forever begin
			idle = 0;
			@(posedge clk);
			while (!uops.mem_req) begin
				idle++;
				if (idle > WAIT_LIMIT)
					timed_out("a memory request");
				@(posedge clk);
			end
			lcg_state = lcg_next(lcg_state);
			delay = 1 + int'((lcg_state >> 16) % 32'd6);
			repeat (delay) @(posedge clk);
			#2;
			// only a fetch consumes a program word
			if (state == st_p1) begin
				instr = prog[pc];
				pc = (pc + 1) % PROG_LEN;
			end
			mem_done = 1'b1;
			@(posedge clk);
			#2 mem_done = 1'b0;
		end
	end

	initial begin : stimulus
		rst = 1'b1;
		start_req = 1'b0;
		stop_req = 1'b0;
		irq = 1'b0;
		irq_mask = 1'b0;
		prog[0] = encode(6'd10, 3'd1, 3'd0, 3'd0);
		prog[1] = encode(6'd11, 3'd2, 3'd5, 3'd0);
		prog[2] = encode(6'd12, 3'd3, 3'd4, 3'd1);
		prog[3] = encode(`PM_OP_SHIFT, 3'd0, 3'd0, 3'd5);
		prog[4] = encode(`PM_OP_LRG, 3'd6, 3'd0, 3'd2);
		prog[5] = encode(`PM_OP_HLT, 3'd0, 3'd0, 3'd1);
		prog[6] = encode(`PM_OP_SHIFT, 3'd0, 3'd1, 3'd1);
		prog[7] = encode(6'd13, 3'd7, 3'd0, 3'd3);
		repeat (10) @(posedge clk);
		#2 rst = 1'b0;
		repeat (4) @(posedge clk);

		// program runs up to its HLT
		pulse_start();
		wait_for_state(st_p1, "the first fetch");
		wait_for_state(st_p0, "the halt");

		// restart with a masked interrupt pending
		#2;
		irq = 1'b1;
		irq_mask = 1'b1;
		pulse_start();
		wait_for_state(st_p1, "the fetch after restart");
		wait_for_state(st_p4, "the shift");
		wait_for_state(st_p1, "the fetch after the shift");
		wait_for_state(st_p4, "the execute step");
		wait_for_state(st_p1, "the next fetch");

		// unmask so the interrupt is taken after this instruction
		#2 irq_mask = 1'b0;
		wait_for_state(st_p5, "the interrupt accept");
		wait_for_state(st_p1, "the fetch after the interrupt");
		#2 irq = 1'b0;
		pulse_stop();
		wait_for_state(st_p0, "the stop");
		repeat (4) @(posedge clk);
		$display("All tests passed!");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+include
src/pm_pkg.sv
src/pm_timing.sv
src/pm_sequencer.sv
src/pm_counters.sv
src/pm_microops.sv
src/pm_top.sv
sim/tb_pm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the P-M testbench with Verilator
set -u
cd "$(dirname "$0")"

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_pm --Mdir "$BUILD" -o tb_pm -f verilog.f
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

"./$BUILD/tb_pm" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "simulation failed"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
echo "simulation finished without failures"
exit 0
